// File: miniSoc.f
+incdir+.
miniSocPkg.sv
sramBank.sv
dmaBeatCounter.sv
dmaController.sv
hostBridge.sv
miniSoc.sv
miniSoc_assertions.sv
miniSoc_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the miniSoc simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module miniSoc_tb \
	-f miniSoc.f -o miniSocSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/miniSocSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
	exit 0
else
	exit 1
fi

// File: miniSoc_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "miniSoc_defs.svh"

module miniSoc_tb;

	localparam int ReqTimeout = 2000;
	localparam int RspTimeout = 20;
	localparam int IrqTimeout = 2000;

	logic clk;
	logic arstN;
	miniSocPkg::busReq_t req;
	logic reqValid;
	logic reqReady;
	miniSocPkg::busRsp_t rsp;
	logic rspValid;
	logic rspReady;
	logic dmaInterrupt;

	// Reference model of the SRAM and the DMA interrupt
	logic [31:0] modelMem [`SRAM_WORDS];
	logic modelIrq;
	integer seed;
	int stallCount;
	logic irqAtAccept;

	miniSoc uut (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.rsp(rsp),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.dmaInterrupt(dmaInterrupt)
	);

	always #50 clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic checkEq(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			abortRun($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected));
		end
	endtask

	function automatic int unsigned randBelow(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [15:0] sramAddr(input logic [7:0] idx);
		return {`REGION_SRAM, 2'b00, idx, 2'b00};
	endfunction

	function automatic logic [15:0] regAddr(input logic [7:0] offset);
		return {`REGION_DMA, 4'h0, offset};
	endfunction

	// One host transfer, with random delay before the response is taken
	task automatic busTransfer(input logic write, input logic [15:0] addr,
		input logic [31:0] wdata, input logic [3:0] strb,
		output logic [31:0] rdata, output logic error);
		int waited;
		int delay;
		@(posedge clk);
		req.write <= write;
		req.addr <= addr;
		req.wdata <= wdata;
		req.strb <= strb;
		reqValid <= 1'b1;
		stallCount = 0;
		@(negedge clk);
		while (!reqReady) begin
			stallCount++;
			if (stallCount > ReqTimeout) begin
				abortRun("Timeout: the bridge never accepted the request");
			end
			@(negedge clk);
		end
		irqAtAccept = dmaInterrupt;
		@(posedge clk);
		reqValid <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (!rspValid) begin
			waited++;
			if (waited > RspTimeout) begin
				abortRun("Timeout: no response arrived after the request was accepted");
			end
			@(negedge clk);
		end
		checkEq("rspValid latency", waited, 1);
		delay = randBelow(4);
		repeat (delay) @(posedge clk);
		@(posedge clk);
		rspReady <= 1'b1;
		// Payload is taken in the handshake cycle, after any back-pressure
		@(negedge clk);
		checkEq("rspValid", rspValid, 1);
		rdata = rsp.rdata;
		error = rsp.error;
		@(posedge clk);
		rspReady <= 1'b0;
	endtask

	task automatic writeWord(input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] rdata;
		logic error;
		busTransfer(1'b1, addr, data, strb, rdata, error);
		checkEq("rsp.error", error, 0);
		checkEq("rsp.rdata", rdata, 0);
	endtask

	task automatic readExpect(input logic [15:0] addr, input logic [31:0] expected);
		logic [31:0] rdata;
		logic error;
		busTransfer(1'b0, addr, 32'h0, 4'h0, rdata, error);
		checkEq("rsp.error", error, 0);
		checkEq("rsp.rdata", rdata, expected);
	endtask

	task automatic modelWrite(input logic [7:0] idx, input logic [31:0] data,
		input logic [3:0] strb);
		for (int lane = 0; lane < 4; lane++) begin
			if (strb[lane]) begin
				modelMem[idx][lane*8 +: 8] = data[lane*8 +: 8];
			end
		end
	endtask

	task automatic copyModel(input logic [7:0] src, input logic [7:0] dst, input logic [7:0] len);
		for (int i = 0; i < len; i++) begin
			modelMem[8'(dst + i)] = modelMem[8'(src + i)];
		end
	endtask

	task automatic verifySram();
		for (int i = 0; i < `SRAM_WORDS; i++) begin
			readExpect(sramAddr(8'(i)), modelMem[i]);
		end
	endtask

	task automatic startCopy(input logic [7:0] src, input logic [7:0] dst, input logic [7:0] len);
		writeWord(regAddr(`DMA_REG_SRC), {24'h0, src}, 4'hf);
		writeWord(regAddr(`DMA_REG_DST), {24'h0, dst}, 4'hf);
		writeWord(regAddr(`DMA_REG_LEN), {24'h0, len}, 4'hf);
		writeWord(regAddr(`DMA_REG_CTRL), 32'h1, 4'hf);
	endtask

	task automatic waitForInterrupt();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!dmaInterrupt) begin
			waited++;
			if (waited > IrqTimeout) begin
				abortRun("Timeout: the DMA copy never raised its interrupt");
			end
			@(negedge clk);
		end
	endtask

	task automatic clearInterrupt();
		writeWord(regAddr(`DMA_REG_CTRL), 32'h2, 4'hf);
		modelIrq = 1'b0;
		@(negedge clk);
		checkEq("dmaInterrupt", dmaInterrupt, modelIrq);
	endtask

	initial begin
		logic [7:0] idx;
		logic [7:0] src;
		logic [7:0] dst;
		logic [7:0] len;
		logic [31:0] data;
		logic [31:0] rdata;
		logic [3:0] strb;
		logic [15:0] addr;
		logic error;
		seed = 42015;
		clk = 1'b0;
		arstN = 1'b0;
		req = '0;
		reqValid = 1'b0;
		rspReady = 1'b0;
		modelIrq = 1'b0;
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkEq("reqReady", reqReady, 1);
		checkEq("rspValid", rspValid, 0);
		checkEq("dmaInterrupt", dmaInterrupt, 0);

		// Full fill, then random strobed writes
		for (int i = 0; i < `SRAM_WORDS; i++) begin
			data = $random(seed);
			writeWord(sramAddr(8'(i)), data, 4'hf);
			modelWrite(8'(i), data, 4'hf);
		end
		for (int i = 0; i < 64; i++) begin
			idx = 8'(randBelow(`SRAM_WORDS));
			data = $random(seed);
			strb = 4'(randBelow(16));
			writeWord(sramAddr(idx), data, strb);
			modelWrite(idx, data, strb);
		end
		verifySram();

		// Register readback
		src = 8'(randBelow(256));
		dst = 8'(randBelow(256));
		len = 8'(randBelow(256));
		writeWord(regAddr(`DMA_REG_SRC), {24'h0, src}, 4'hf);
		writeWord(regAddr(`DMA_REG_DST), {24'h0, dst}, 4'hf);
		writeWord(regAddr(`DMA_REG_LEN), {24'h0, len}, 4'hf);
		readExpect(regAddr(`DMA_REG_SRC), {24'h0, src});
		readExpect(regAddr(`DMA_REG_DST), {24'h0, dst});
		readExpect(regAddr(`DMA_REG_LEN), {24'h0, len});
		readExpect(regAddr(`DMA_REG_CTRL), 32'h0);
		readExpect(regAddr(8'h10), 32'h0);

		// Copy between non-overlapping halves
		src = 8'(randBelow(112));
		dst = 8'(128 + randBelow(112));
		len = 8'(4 + randBelow(13));
		startCopy(src, dst, len);
		waitForInterrupt();
		copyModel(src, dst, len);
		modelIrq = 1'b1;
		readExpect(regAddr(`DMA_REG_CTRL), {30'h0, modelIrq, 1'b0});
		for (int i = 0; i < len; i++) begin
			readExpect(sramAddr(8'(dst + i)), modelMem[8'(dst + i)]);
		end
		clearInterrupt();

		// Host write to a destination word while the copy runs
		src = 8'(randBelow(112));
		dst = 8'(128 + randBelow(112));
		len = 8'(8 + randBelow(9));
		startCopy(src, dst, len);
		idx = 8'(dst + randBelow(len));
		data = $random(seed);
		writeWord(sramAddr(idx), data, 4'hf);
		checkEq("reqReady stalled during copy", stallCount > 0, 1);
		checkEq("dmaInterrupt at accept", irqAtAccept, 1);
		copyModel(src, dst, len);
		modelWrite(idx, data, 4'hf);
		readExpect(sramAddr(idx), data);
		clearInterrupt();

		// Unmapped regions
		for (int i = 0; i < 8; i++) begin
			data = $random(seed);
			addr = {4'(2 + randBelow(14)), data[11:0]};
			busTransfer(1'(randBelow(2)), addr, $random(seed), 4'hf, rdata, error);
			checkEq("rsp.error", error, 1);
			checkEq("rsp.rdata", rdata, 0);
		end
		verifySram();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: miniSoc_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module miniSoc_assertions (
	input logic clk,
	input logic arstN,
	input logic reqValid,
	input logic reqReady,
	input miniSocPkg::busRsp_t rsp,
	input logic rspValid,
	input logic rspReady
);

	logic accept;

	assign accept = reqValid && reqReady;

	// Response held under back-pressure
	rspHeld: assert property (@(posedge clk) disable iff (!arstN)
		rspValid && !rspReady |=> rspValid && (rsp == $past(rsp)))
		else $error("rsp or rspValid changed while waiting for rspReady");

	// One request in flight
	noAcceptWithRsp: assert property (@(posedge clk) disable iff (!arstN)
		rspValid |-> !reqReady)
		else $error("reqReady high while a response is pending");

	// Fixed response latency of two cycles
	rspNotEarly: assert property (@(posedge clk) disable iff (!arstN)
		$past(accept) |-> !rspValid)
		else $error("rspValid one cycle after acceptance");

	rspOnTime: assert property (@(posedge clk) disable iff (!arstN)
		$past(accept, 2) |-> rspValid)
		else $error("rspValid missing two cycles after acceptance");

	rspHasRequest: assert property (@(posedge clk) disable iff (!arstN)
		$rose(rspValid) |-> $past(accept, 2))
		else $error("rspValid rose without a request two cycles earlier");

endmodule

bind hostBridge miniSoc_assertions handshakeChecks (
	.clk(clk),
	.arstN(arstN),
	.reqValid(reqValid),
	.reqReady(reqReady),
	.rsp(rsp),
	.rspValid(rspValid),
	.rspReady(rspReady)
);

`default_nettype wire

// File: miniSoc.sv
`timescale 1ns/10ps
`default_nettype none

`include "miniSoc_defs.svh"

module miniSoc (
	input logic clk,
	input logic arstN,
	input miniSocPkg::busReq_t req,
	input logic reqValid,
	output logic reqReady,
	output miniSocPkg::busRsp_t rsp,
	output logic rspValid,
	input logic rspReady,
	output logic dmaInterrupt
);

	// Bridge to DMA register port
	logic regWrite;
	logic regRead;
	logic [7:0] regOffset;
	miniSocPkg::dmaRegWord_u regWdata;
	logic [`SOC_DATA_BITS-1:0] regRdata;
	logic busy;

	// SRAM paths
	miniSocPkg::sramReq_t dmaSram;
	miniSocPkg::sramReq_t sramPort;
	logic [`SOC_DATA_BITS-1:0] sramRdata;

	hostBridge bridge (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.rsp(rsp),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.regWrite(regWrite),
		.regRead(regRead),
		.regOffset(regOffset),
		.regWdata(regWdata),
		.regRdata(regRdata),
		.busy(busy),
		.dmaSram(dmaSram),
		.sramPort(sramPort),
		.sramRdata(sramRdata)
	);

	dmaController dma (
		.clk(clk),
		.arstN(arstN),
		.regWrite(regWrite),
		.regRead(regRead),
		.regOffset(regOffset),
		.regWdata(regWdata),
		.regRdata(regRdata),
		.busy(busy),
		.dmaSram(dmaSram),
		.sramRdata(sramRdata),
		.dmaInterrupt(dmaInterrupt)
	);

	sramBank dataSram (
		.clk(clk),
		.arstN(arstN),
		.port(sramPort),
		.rdata(sramRdata)
	);

endmodule

`default_nettype wire

// File: hostBridge.sv
`timescale 1ns/10ps
`default_nettype none

`include "miniSoc_defs.svh"

module hostBridge (
	input logic clk,
	input logic arstN,
	input miniSocPkg::busReq_t req,
	input logic reqValid,
	output logic reqReady,
	output miniSocPkg::busRsp_t rsp,
	output logic rspValid,
	input logic rspReady,
	output logic regWrite,
	output logic regRead,
	output logic [7:0] regOffset,
	output miniSocPkg::dmaRegWord_u regWdata,
	input logic [`SOC_DATA_BITS-1:0] regRdata,
	input logic busy,
	input miniSocPkg::sramReq_t dmaSram,
	output miniSocPkg::sramReq_t sramPort,
	input logic [`SOC_DATA_BITS-1:0] sramRdata
);

	logic [3:0] reqRegion;
	logic [3:0] pendRegion;
	logic reqToSram;
	logic accept;
	logic pendValid;
	miniSocPkg::busReq_t pendReq;
	miniSocPkg::sramReq_t hostSram;
	miniSocPkg::busRsp_t rspNext;

	assign reqRegion = req.addr[`SOC_ADDR_BITS-1 -: 4];
	assign reqToSram = (reqRegion == `REGION_SRAM);

	// One request in flight, and SRAM traffic waits out a copy
	assign reqReady = !pendValid && !rspValid && !(busy && reqToSram);
	assign accept = reqValid && reqReady;

	// Host access goes out in the accept cycle so read data is back one cycle later
	always_comb begin
		hostSram.en = accept && reqToSram;
		hostSram.we = req.write;
		hostSram.idx = req.addr[`SRAM_IDX_BITS+1:2];
		hostSram.wdata = req.wdata;
		hostSram.strb = req.strb;
	end

	assign sramPort = busy ? dmaSram : hostSram;

	// First pending stage
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pendValid <= 1'b0;
		end else begin
			pendValid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pendReq <= req;
		end
	end

	assign pendRegion = pendReq.addr[`SOC_ADDR_BITS-1 -: 4];

	// Register access happens in the first pending cycle
	assign regWrite = pendValid && (pendRegion == `REGION_DMA) && pendReq.write;
	assign regRead = pendValid && (pendRegion == `REGION_DMA) && !pendReq.write;
	assign regOffset = pendReq.addr[7:0];
	assign regWdata = pendReq.wdata;

	// Unmapped regions answer with an error and zero data
	always_comb begin
		rspNext.rdata = '0;
		rspNext.error = 1'b0;
		case (pendRegion)
			`REGION_SRAM: begin
				if (!pendReq.write) begin
					rspNext.rdata = sramRdata;
				end
			end
			`REGION_DMA: rspNext.rdata = regRdata;
			default: rspNext.error = 1'b1;
		endcase
	end

	// Second stage is the response itself, held until taken
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rspValid <= 1'b0;
		end else if (pendValid) begin
			rspValid <= 1'b1;
		end else if (rspReady) begin
			rspValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pendValid) begin
			rsp <= rspNext;
		end
	end

endmodule

`default_nettype wire

// File: dmaController.sv
`timescale 1ns/10ps
`default_nettype none

`include "miniSoc_defs.svh"

module dmaController (
	input logic clk,
	input logic arstN,
	input logic regWrite,
	input logic regRead,
	input logic [7:0] regOffset,
	input miniSocPkg::dmaRegWord_u regWdata,
	output logic [`SOC_DATA_BITS-1:0] regRdata,
	output logic busy,
	output miniSocPkg::sramReq_t dmaSram,
	input logic [`SOC_DATA_BITS-1:0] sramRdata,
	output logic dmaInterrupt
);

	typedef enum logic [1:0] {
		Idle,
		Read,
		Write,
		Done
	} dmaState_t;

	dmaState_t state;
	dmaState_t stateNext;
	logic [`SRAM_IDX_BITS-1:0] srcReg;
	logic [`SRAM_IDX_BITS-1:0] dstReg;
	logic [`SRAM_IDX_BITS-1:0] lenReg;
	logic [`SRAM_IDX_BITS-1:0] index;
	logic irqFlag;
	logic ctrlWrite;
	logic startReq;
	logic load;
	logic step;
	logic last;

	assign busy = (state != Idle);
	assign dmaInterrupt = irqFlag;
	assign ctrlWrite = regWrite && (regOffset == `DMA_REG_CTRL);
	assign startReq = ctrlWrite && regWdata.ctrl.start && !busy;
	// Zero length never enters the copy loop
	assign load = startReq && (lenReg != '0);

	// Config registers are frozen during a copy
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			srcReg <= '0;
			dstReg <= '0;
			lenReg <= '0;
		end else if (regWrite && !busy) begin
			case (regOffset)
				`DMA_REG_SRC: srcReg <= regWdata.raw[`SRAM_IDX_BITS-1:0];
				`DMA_REG_DST: dstReg <= regWdata.raw[`SRAM_IDX_BITS-1:0];
				`DMA_REG_LEN: lenReg <= regWdata.raw[`SRAM_IDX_BITS-1:0];
				default: ;
			endcase
		end
	end

	// A completing copy wins over a clear in the same cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			irqFlag <= 1'b0;
		end else begin
			if (ctrlWrite && regWdata.ctrl.irqClear) begin
				irqFlag <= 1'b0;
			end
			if ((state == Done) || (startReq && (lenReg == '0))) begin
				irqFlag <= 1'b1;
			end
		end
	end

	always_comb begin
		regRdata = '0;
		if (regRead) begin
			case (regOffset)
				`DMA_REG_SRC: regRdata = {{(`SOC_DATA_BITS-`SRAM_IDX_BITS){1'b0}}, srcReg};
				`DMA_REG_DST: regRdata = {{(`SOC_DATA_BITS-`SRAM_IDX_BITS){1'b0}}, dstReg};
				`DMA_REG_LEN: regRdata = {{(`SOC_DATA_BITS-`SRAM_IDX_BITS){1'b0}}, lenReg};
				`DMA_REG_CTRL: regRdata = {{(`SOC_DATA_BITS-2){1'b0}}, irqFlag, busy};
				default: ;
			endcase
		end
	end

	// One read then one write per word
	always_comb begin
		stateNext = state;
		step = 1'b0;
		case (state)
			Idle: begin
				if (load) begin
					stateNext = Read;
				end
			end
			Read: stateNext = Write;
			Write: begin
				if (last) begin
					stateNext = Done;
				end else begin
					step = 1'b1;
					stateNext = Read;
				end
			end
			Done: stateNext = Idle;
			default: stateNext = Idle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= Idle;
		end else begin
			state <= stateNext;
		end
	end

	// Write data is the SRAM output registered by the preceding read
	always_comb begin
		dmaSram = '0;
		case (state)
			Read: begin
				dmaSram.en = 1'b1;
				dmaSram.idx = srcReg + index;
			end
			Write: begin
				dmaSram.en = 1'b1;
				dmaSram.we = 1'b1;
				dmaSram.idx = dstReg + index;
				dmaSram.wdata = sramRdata;
				dmaSram.strb = '1;
			end
			default: ;
		endcase
	end

	dmaBeatCounter beatCounter (
		.clk(clk),
		.arstN(arstN),
		.load(load),
		.len(lenReg),
		.step(step),
		.index(index),
		.last(last)
	);

endmodule

`default_nettype wire

// File: dmaBeatCounter.sv
`timescale 1ns/10ps
`default_nettype none

`include "miniSoc_defs.svh"

module dmaBeatCounter (
	input logic clk,
	input logic arstN,
	input logic load,
	input logic [`SRAM_IDX_BITS-1:0] len,
	input logic step,
	output logic [`SRAM_IDX_BITS-1:0] index,
	output logic last
);

	logic [`SRAM_IDX_BITS-1:0] lenReg;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			lenReg <= '0;
			index <= '0;
		end else if (load) begin
			lenReg <= len;
			index <= '0;
		end else if (step) begin
			index <= index + 1'b1;
		end
	end

	// Final word of the transfer
	assign last = (index == lenReg - 1'b1);

endmodule

`default_nettype wire

// File: sramBank.sv
`timescale 1ns/10ps
`default_nettype none

`include "miniSoc_defs.svh"

module sramBank (
	input logic clk,
	input logic arstN,
	input miniSocPkg::sramReq_t port,
	output logic [`SOC_DATA_BITS-1:0] rdata
);

	logic [`SOC_DATA_BITS-1:0] mem [`SRAM_WORDS];
	logic readEn;
	logic writeEn;

	assign readEn = port.en && !port.we;
	assign writeEn = port.en && port.we;

	// Byte lane writes
	always_ff @(posedge clk) begin
		if (writeEn) begin
			for (int lane = 0; lane < `SOC_STRB_BITS; lane++) begin
				if (port.strb[lane]) begin
					mem[port.idx][lane*8 +: 8] <= port.wdata[lane*8 +: 8];
				end
			end
		end
	end

	// Read data lands one cycle after the read and holds until the next read
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdata <= '0;
		end else if (readEn) begin
			rdata <= mem[port.idx];
		end
	end

endmodule

`default_nettype wire

// File: miniSocPkg.sv
`default_nettype none

`include "miniSoc_defs.svh"

package miniSocPkg;

	// Host request, one 32-bit word per transfer
	typedef struct packed {
		logic write;
		logic [`SOC_ADDR_BITS-1:0] addr;
		logic [`SOC_DATA_BITS-1:0] wdata;
		logic [`SOC_STRB_BITS-1:0] strb;
	} busReq_t;

	// Host response
	typedef struct packed {
		logic [`SOC_DATA_BITS-1:0] rdata;
		logic error;
	} busRsp_t;

	// Single SRAM access, word indexed
	typedef struct packed {
		logic en;
		logic we;
		logic [`SRAM_IDX_BITS-1:0] idx;
		logic [`SOC_DATA_BITS-1:0] wdata;
		logic [`SOC_STRB_BITS-1:0] strb;
	} sramReq_t;

	// CTRL register bits as seen by a write
	typedef struct packed {
		logic [`SOC_DATA_BITS-3:0] reserved;
		logic irqClear;
		logic start;
	} dmaCtrlBits_t;

	// Register write word, raw for SRC/DST/LEN, decoded for CTRL
	typedef union packed {
		logic [`SOC_DATA_BITS-1:0] raw;
		dmaCtrlBits_t ctrl;
	} dmaRegWord_u;

endpackage

`default_nettype wire

// File: miniSoc_defs.svh
`ifndef MINISOC_DEFS_SVH
`define MINISOC_DEFS_SVH

// Bus geometry
`define SOC_DATA_BITS 32
`define SOC_ADDR_BITS 16
`define SOC_STRB_BITS 4

// Data SRAM depth and word index width
`define SRAM_WORDS 256
`define SRAM_IDX_BITS 8

// Address map, top nibble of the byte address
`define REGION_SRAM 4'h0
`define REGION_DMA 4'h1

// DMA register byte offsets
`define DMA_REG_SRC 8'h00
`define DMA_REG_DST 8'h04
`define DMA_REG_LEN 8'h08
`define DMA_REG_CTRL 8'h0c

`endif
